// File: logic/femto_bus_pkg.sv
package femto_bus_pkg;

    // ======================================================================
    // bus widths
    // ======================================================================

    localparam int xlen      = 32; // address width.
    localparam int bus_width = 32; // data width.

    // ======================================================================
    // access sizes
    // ======================================================================

    localparam int bus_acc_cnt = 3;
    localparam int acc_w       = $clog2(bus_acc_cnt);

    localparam logic [acc_w-1:0] acc_byte = 2'd0;
    localparam logic [acc_w-1:0] acc_half = 2'd1;
    localparam logic [acc_w-1:0] acc_word = 2'd2;

    // ======================================================================
    // bus word
    // ======================================================================

    // one stored word, seen whole or by lanes.
    typedef union packed {
        logic [bus_width-1:0]                w; // full word.
        logic [1:0][bus_width/2-1:0]         h; // half lanes, h[1] is the upper half.
        logic [bus_width/8-1:0][7:0]         b; // byte lanes, b[0] at the lowest address.
    } bus_word_t;

endpackage

// File: logic/femto_map_pkg.sv
package femto_map_pkg;

    // ======================================================================
    // memory map
    // ======================================================================

    // boot rom, 64 bytes.
    localparam logic [femto_bus_pkg::xlen-1:0] rom_base = 32'h0000_0000;
    localparam int rom_span = 6;

    // tightly coupled memory, 1 KB.
    localparam logic [femto_bus_pkg::xlen-1:0] tcm_base = 32'h1000_0000;
    localparam int tcm_span = 10;

    // general sram, 4 KB.
    localparam logic [femto_bus_pkg::xlen-1:0] sram_base = 32'h2000_0000;
    localparam int sram_span = 12;

    localparam int slave_cnt = 3; // rom, tcm, sram.

endpackage

// File: logic/dbus_rom.sv
`timescale 1ns/1ps

module dbus_rom (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 req,
    input  logic [femto_bus_pkg::xlen-1:0]       addr,
    output logic                                 resp,
    output logic [femto_bus_pkg::bus_width-1:0]  rdata
);

    logic [femto_bus_pkg::bus_width-1:0] boot_word;

    // ======================================================================
    // boot table
    // ======================================================================

    always_comb begin
        case (addr[5:2])
            4'd0:  boot_word = 32'h1000_0137; // stack at top of tcm.
            4'd1:  boot_word = 32'h4001_0113;
            4'd2:  boot_word = 32'h2000_02b7; // sram base.
            4'd3:  boot_word = 32'h0000_0313;
            4'd4:  boot_word = 32'h0062_a023; // clear loop.
            4'd5:  boot_word = 32'h0042_8293;
            4'd6:  boot_word = 32'h0013_0313;
            4'd7:  boot_word = 32'h0100_0393;
            4'd8:  boot_word = 32'hfe73_48e3;
            4'd9:  boot_word = 32'h0000_006f; // spin.
            4'd10: boot_word = 32'h0000_0013;
            4'd11: boot_word = 32'h0010_0073;
            4'd12: boot_word = 32'h3020_0073; // trap return.
            4'd13: boot_word = 32'h1050_0073;
            4'd14: boot_word = 32'h5a5a_0f0f; // id words.
            default: boot_word = 32'ha5a5_5a5a;
        endcase
    end

    // writes are answered like reads and leave the table unchanged.
    always_ff @(posedge clk) begin
        if (req) rdata <= boot_word;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp <= 1'b0;
        end else begin
            resp <= req;
        end
    end

endmodule

// File: logic/dbus_tcm.sv
`timescale 1ns/1ps

module dbus_tcm #(
    parameter int addr_span = 10 // byte address bits.
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 req,
    input  logic [femto_bus_pkg::xlen-1:0]       addr,
    input  logic                                 w_rb,
    input  logic [femto_bus_pkg::acc_w-1:0]      acc,
    input  logic [femto_bus_pkg::bus_width-1:0]  wdata,
    output logic                                 resp,
    output logic [femto_bus_pkg::bus_width-1:0]  rdata
);

    localparam int depth = 1 << (addr_span - 2);

    femto_bus_pkg::bus_word_t mem [0:depth-1];

    logic [addr_span-3:0]     word_idx;
    femto_bus_pkg::bus_word_t wr_lanes; // write data by lane.
    femto_bus_pkg::bus_word_t merged;   // stored word with new lanes applied.

    assign word_idx = addr[addr_span-1:2];
    assign wr_lanes = wdata;

    // ======================================================================
    // write lane merge
    // ======================================================================

    always_comb begin
        merged = mem[word_idx];
        case (acc)
            femto_bus_pkg::acc_byte: merged.b[addr[1:0]] = wr_lanes.b[addr[1:0]];
            femto_bus_pkg::acc_half: merged.h[addr[1]] = wr_lanes.h[addr[1]];
            femto_bus_pkg::acc_word: merged.w = wr_lanes.w;
            default: ; // unknown size leaves the word alone.
        endcase
    end

    always_ff @(posedge clk) begin
        if (req && w_rb) begin
            mem[word_idx] <= merged;
        end
        if (req) begin
            rdata <= mem[word_idx].w; // aligned word, old contents on a write.
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp <= 1'b0;
        end else begin
            resp <= req;
        end
    end

    // the master must keep accesses naturally aligned.
    a_half_aligned : assert property (@(posedge clk) disable iff (rst)
        (req && acc == femto_bus_pkg::acc_half) |-> !addr[0])
        else $error("dbus_tcm: misaligned half access at %h", addr);

    a_word_aligned : assert property (@(posedge clk) disable iff (rst)
        (req && acc == femto_bus_pkg::acc_word) |-> addr[1:0] == 2'b00)
        else $error("dbus_tcm: misaligned word access at %h", addr);

endmodule

// File: logic/dbus_conn.sv
`timescale 1ns/1ps

module dbus_conn (
    input  logic                                  m_req,
    input  logic [femto_bus_pkg::xlen-1:0]        m_addr,
    input  logic                                  m_w_rb,
    input  logic [femto_bus_pkg::acc_w-1:0]       m_acc,
    input  logic [femto_bus_pkg::bus_width-1:0]   m_wdata,
    output logic                                  m_resp,
    output logic [femto_bus_pkg::bus_width-1:0]   m_rdata,

    output logic                                  s_rom_req,
    output logic [femto_bus_pkg::xlen-1:0]        s_rom_addr,
    output logic                                  s_rom_w_rb,
    output logic [femto_bus_pkg::acc_w-1:0]       s_rom_acc,
    output logic [femto_bus_pkg::bus_width-1:0]   s_rom_wdata,
    input  logic                                  s_rom_resp,
    input  logic [femto_bus_pkg::bus_width-1:0]   s_rom_rdata,

    output logic                                  s_tcm_req,
    output logic [femto_bus_pkg::xlen-1:0]        s_tcm_addr,
    output logic                                  s_tcm_w_rb,
    output logic [femto_bus_pkg::acc_w-1:0]       s_tcm_acc,
    output logic [femto_bus_pkg::bus_width-1:0]   s_tcm_wdata,
    input  logic                                  s_tcm_resp,
    input  logic [femto_bus_pkg::bus_width-1:0]   s_tcm_rdata,

    output logic                                  s_sram_req,
    output logic [femto_bus_pkg::xlen-1:0]        s_sram_addr,
    output logic                                  s_sram_w_rb,
    output logic [femto_bus_pkg::acc_w-1:0]       s_sram_acc,
    output logic [femto_bus_pkg::bus_width-1:0]   s_sram_wdata,
    input  logic                                  s_sram_resp,
    input  logic [femto_bus_pkg::bus_width-1:0]   s_sram_rdata,

    output logic                                  bus_fault, // no slave selected.
    input  logic                                  bus_halt   // hides the response.
);

    logic [femto_map_pkg::slave_cnt-1:0] bus_slave_sel;

    // true when addr lies in the region base .. base + 2**span - 1.
    function automatic logic region_hit(
        input logic [femto_bus_pkg::xlen-1:0] addr,
        input logic [femto_bus_pkg::xlen-1:0] base,
        input int                             span
    );
        return (addr >> span) == (base >> span);
    endfunction

    // ======================================================================
    // address decode and request fan-out
    // ======================================================================

    always_comb begin
        bus_slave_sel[0] = region_hit(m_addr, femto_map_pkg::rom_base,
                                      femto_map_pkg::rom_span);
        bus_slave_sel[1] = region_hit(m_addr, femto_map_pkg::tcm_base,
                                      femto_map_pkg::tcm_span);
        bus_slave_sel[2] = region_hit(m_addr, femto_map_pkg::sram_base,
                                      femto_map_pkg::sram_span);
    end

    assign s_rom_req   = m_req & bus_slave_sel[0];
    assign s_rom_addr  = m_addr;
    assign s_rom_w_rb  = m_w_rb;
    assign s_rom_acc   = m_acc;
    assign s_rom_wdata = m_wdata;

    assign s_tcm_req   = m_req & bus_slave_sel[1];
    assign s_tcm_addr  = m_addr;
    assign s_tcm_w_rb  = m_w_rb;
    assign s_tcm_acc   = m_acc;
    assign s_tcm_wdata = m_wdata;

    assign s_sram_req   = m_req & bus_slave_sel[2];
    assign s_sram_addr  = m_addr;
    assign s_sram_w_rb  = m_w_rb;
    assign s_sram_acc   = m_acc;
    assign s_sram_wdata = m_wdata;

    assign bus_fault = m_req & ~|bus_slave_sel;

    // ======================================================================
    // response mux
    // ======================================================================

    always_comb begin
        if (s_rom_resp) m_rdata = s_rom_rdata;
        else if (s_tcm_resp) m_rdata = s_tcm_rdata;
        else if (s_sram_resp) m_rdata = s_sram_rdata;
        else m_rdata = '0; // idle bus reads zero.
    end

    assign m_resp = ~bus_halt & |{s_rom_resp, s_tcm_resp, s_sram_resp};

    // regions in the map must not overlap.
    // equal slave latency keeps responses one per cycle.
    always_comb begin
        assert final ($onehot0(bus_slave_sel))
            else $error("dbus_conn: address %h selects more than one slave", m_addr);
        assert final ($onehot0({s_rom_resp, s_tcm_resp, s_sram_resp}))
            else $error("dbus_conn: two slaves responded in one cycle");
    end

endmodule

// File: logic/dbus_subsys.sv
`timescale 1ns/1ps

module dbus_subsys (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 m_req,
    input  logic [femto_bus_pkg::xlen-1:0]       m_addr,
    input  logic                                 m_w_rb,
    input  logic [femto_bus_pkg::acc_w-1:0]      m_acc,
    input  logic [femto_bus_pkg::bus_width-1:0]  m_wdata,
    input  logic                                 bus_halt,
    output logic                                 m_resp,
    output logic [femto_bus_pkg::bus_width-1:0]  m_rdata,
    output logic                                 bus_fault
);

    // ======================================================================
    // slave side wires
    // ======================================================================

    logic                                 rom_req, rom_resp;
    logic [femto_bus_pkg::xlen-1:0]       rom_addr;
    logic [femto_bus_pkg::bus_width-1:0]  rom_rdata;

    logic                                 tcm_req, tcm_w_rb, tcm_resp;
    logic [femto_bus_pkg::xlen-1:0]       tcm_addr;
    logic [femto_bus_pkg::acc_w-1:0]      tcm_acc;
    logic [femto_bus_pkg::bus_width-1:0]  tcm_wdata, tcm_rdata;

    logic                                 sram_req, sram_w_rb, sram_resp;
    logic [femto_bus_pkg::xlen-1:0]       sram_addr;
    logic [femto_bus_pkg::acc_w-1:0]      sram_acc;
    logic [femto_bus_pkg::bus_width-1:0]  sram_wdata, sram_rdata;

    dbus_conn conn (
        .m_req(m_req), .m_addr(m_addr), .m_w_rb(m_w_rb), .m_acc(m_acc),
        .m_wdata(m_wdata), .m_resp(m_resp), .m_rdata(m_rdata),
        // rom takes address only.
        .s_rom_req(rom_req), .s_rom_addr(rom_addr), .s_rom_w_rb(), .s_rom_acc(),
        .s_rom_wdata(), .s_rom_resp(rom_resp), .s_rom_rdata(rom_rdata),
        .s_tcm_req(tcm_req), .s_tcm_addr(tcm_addr), .s_tcm_w_rb(tcm_w_rb),
        .s_tcm_acc(tcm_acc), .s_tcm_wdata(tcm_wdata), .s_tcm_resp(tcm_resp),
        .s_tcm_rdata(tcm_rdata),
        .s_sram_req(sram_req), .s_sram_addr(sram_addr), .s_sram_w_rb(sram_w_rb),
        .s_sram_acc(sram_acc), .s_sram_wdata(sram_wdata), .s_sram_resp(sram_resp),
        .s_sram_rdata(sram_rdata),
        .bus_fault(bus_fault), .bus_halt(bus_halt)
    );

    dbus_rom rom (
        .clk(clk), .rst(rst), .req(rom_req), .addr(rom_addr),
        .resp(rom_resp), .rdata(rom_rdata)
    );

    dbus_tcm #(.addr_span(femto_map_pkg::tcm_span)) tcm (
        .clk(clk), .rst(rst), .req(tcm_req), .addr(tcm_addr), .w_rb(tcm_w_rb),
        .acc(tcm_acc), .wdata(tcm_wdata), .resp(tcm_resp), .rdata(tcm_rdata)
    );

    dbus_tcm #(.addr_span(femto_map_pkg::sram_span)) sram (
        .clk(clk), .rst(rst), .req(sram_req), .addr(sram_addr), .w_rb(sram_w_rb),
        .acc(sram_acc), .wdata(sram_wdata), .resp(sram_resp), .rdata(sram_rdata)
    );

endmodule

// File: verification/tb_dbus_subsys.sv
`timescale 1ns/1ps

module tb_dbus_subsys;

    localparam int clk_period = 20;
    localparam int rst_cycles = 8;
    localparam int max_rows   = 96;

    // boot rom contents, one word per addr[5:2].
    localparam logic [31:0] boot_table [16] = '{
        32'h1000_0137, 32'h4001_0113, 32'h2000_02b7, 32'h0000_0313,
        32'h0062_a023, 32'h0042_8293, 32'h0013_0313, 32'h0100_0393,
        32'hfe73_48e3, 32'h0000_006f, 32'h0000_0013, 32'h0010_0073,
        32'h3020_0073, 32'h1050_0073, 32'h5a5a_0f0f, 32'ha5a5_5a5a
    };

    typedef struct {
        logic        req;
        logic        halt; // halt during this row's response cycle.
        logic [31:0] addr;
        logic        wr;
        logic [1:0]  acc;
        logic [31:0] data;
        logic        exp_fault;
        logic        exp_resp;
        logic        chk_data;
        logic [31:0] exp_rdata;
    } row_t;

    logic        clk;
    logic        rst;
    logic        m_req;
    logic [31:0] m_addr;
    logic        m_w_rb;
    logic [1:0]  m_acc;
    logic [31:0] m_wdata;
    logic        bus_halt;
    logic        m_resp;
    logic [31:0] m_rdata;
    logic        bus_fault;

    row_t rows [0:max_rows-1];
    int   n_rows = 0;
    logic rows_ready = 1'b0;
    int   checks = 0;
    int   errors = 0;
    logic [15:0] lfsr = 16'd25;

    femto_bus_pkg::bus_word_t ref_mem [logic [31:0]]; // keyed by aligned address.

    dbus_subsys uut (
        .clk(clk), .rst(rst), .m_req(m_req), .m_addr(m_addr), .m_w_rb(m_w_rb),
        .m_acc(m_acc), .m_wdata(m_wdata), .bus_halt(bus_halt), .m_resp(m_resp),
        .m_rdata(m_rdata), .bus_fault(bus_fault)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic logic in_region(input logic [31:0] a, input logic [31:0] base,
                                       input int span);
        return (a & ~((32'd1 << span) - 32'd1)) == base;
    endfunction

    // 0 rom, 1 tcm, 2 sram, -1 unmapped.
    function automatic int region_of(input logic [31:0] a);
        if (in_region(a, femto_map_pkg::rom_base, femto_map_pkg::rom_span)) return 0;
        if (in_region(a, femto_map_pkg::tcm_base, femto_map_pkg::tcm_span)) return 1;
        if (in_region(a, femto_map_pkg::sram_base, femto_map_pkg::sram_span)) return 2;
        return -1;
    endfunction

    task automatic add_row(input logic req, input logic halt, input logic [31:0] addr,
                           input logic wr, input logic [1:0] acc, input logic [31:0] data);
        row_t r;
        int region;
        logic [31:0] key;
        femto_bus_pkg::bus_word_t cur;
        femto_bus_pkg::bus_word_t wd;
        region = region_of(addr);
        key = {addr[31:2], 2'b00};
        wd = data;
        r.req = req;
        r.halt = halt;
        r.addr = addr;
        r.wr = wr;
        r.acc = acc;
        r.data = data;
        r.exp_fault = req && region < 0;
        r.exp_resp = req && region >= 0 && !halt;
        r.exp_rdata = '0;
        // a write returns stale tcm data, so only rom write data is compared.
        r.chk_data = (r.exp_resp && (!wr || region == 0)) || !(req && region >= 0);
        if (req && region == 0) begin
            r.exp_rdata = boot_table[addr[5:2]];
        end else if (req && region > 0) begin
            cur = ref_mem.exists(key) ? ref_mem[key] : '0;
            r.exp_rdata = cur.w;
            if (wr) begin
                case (acc)
                    femto_bus_pkg::acc_byte: cur.b[addr[1:0]] = wd.b[addr[1:0]];
                    femto_bus_pkg::acc_half: cur.h[addr[1]] = wd.h[addr[1]];
                    default: cur.w = wd.w;
                endcase
                ref_mem[key] = cur;
            end
        end
        rows[n_rows] = r;
        n_rows++;
    endtask

    task automatic build_rows();
        logic [31:0] a;
        // ==================================================================
        // word traffic and lane merges
        // ==================================================================
        add_row(1'b1, 1'b0, 32'h1000_0000, 1'b1, femto_bus_pkg::acc_word, rand_bits(32));
        add_row(1'b1, 1'b0, 32'h2000_0100, 1'b1, femto_bus_pkg::acc_word, rand_bits(32));
        add_row(1'b1, 1'b0, 32'h1000_03fc, 1'b1, femto_bus_pkg::acc_word, rand_bits(32));
        add_row(1'b1, 1'b0, 32'h2000_0ffc, 1'b1, femto_bus_pkg::acc_word, rand_bits(32));
        add_row(1'b1, 1'b0, 32'h1000_0000, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h2000_0100, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h1000_03fc, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h2000_0ffc, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b0, 1'b0, '0, 1'b0, femto_bus_pkg::acc_word, '0); // idle.
        add_row(1'b1, 1'b0, 32'h1000_0010, 1'b1, femto_bus_pkg::acc_word, 32'h1122_3344);
        for (int k = 0; k < 4; k++) begin
            add_row(1'b1, 1'b0, 32'h1000_0010 + 32'(k), 1'b1, femto_bus_pkg::acc_byte,
                    rand_bits(32));
            add_row(1'b1, 1'b0, 32'h1000_0010, 1'b0, femto_bus_pkg::acc_word, '0);
        end
        add_row(1'b1, 1'b0, 32'h2000_0040, 1'b1, femto_bus_pkg::acc_word, 32'haabb_ccdd);
        for (int k = 0; k < 2; k++) begin
            add_row(1'b1, 1'b0, 32'h2000_0040 + (32'(k) << 1), 1'b1, femto_bus_pkg::acc_half,
                    rand_bits(32));
            add_row(1'b1, 1'b0, 32'h2000_0040, 1'b0, femto_bus_pkg::acc_word, '0);
        end
        // ==================================================================
        // rom, faults, halt, back to back
        // ==================================================================
        for (int k = 0; k < 16; k += 5)
            add_row(1'b1, 1'b0, 32'(k) << 2, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h0000_003a, 1'b0, femto_bus_pkg::acc_byte, '0);
        add_row(1'b1, 1'b0, 32'h0000_0008, 1'b1, femto_bus_pkg::acc_word, rand_bits(32));
        add_row(1'b1, 1'b0, 32'h0000_0008, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h3000_0000, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h1000_0400, 1'b1, femto_bus_pkg::acc_word, rand_bits(32));
        add_row(1'b1, 1'b0, 32'h0000_0040, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h2000_1000, 1'b1, femto_bus_pkg::acc_byte, rand_bits(32));
        add_row(1'b1, 1'b0, 32'h1000_0000, 1'b0, femto_bus_pkg::acc_word, '0); // no alias.
        add_row(1'b1, 1'b1, 32'h1000_0020, 1'b1, femto_bus_pkg::acc_word, rand_bits(32));
        add_row(1'b1, 1'b1, 32'h1000_0020, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h1000_0020, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h0000_0004, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h1000_0010, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h2000_0040, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h0000_003c, 1'b0, femto_bus_pkg::acc_word, '0);
        add_row(1'b1, 1'b0, 32'h2000_0ffc, 1'b0, femto_bus_pkg::acc_word, '0);
        // random sram words, each read straight back.
        for (int k = 0; k < 8; k++) begin
            a = 32'h2000_0000 | (rand_bits(10) << 2);
            add_row(1'b1, 1'b0, a, 1'b1, femto_bus_pkg::acc_word, rand_bits(32));
            add_row(1'b1, 1'b0, a, 1'b0, femto_bus_pkg::acc_word, '0);
        end
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    initial begin
        rst = 1'b1;
        m_req = 1'b0;
        m_addr = '0;
        m_w_rb = 1'b0;
        m_acc = '0;
        m_wdata = '0;
        bus_halt = 1'b0;
        build_rows();
        rows_ready = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i <= n_rows; i++) begin
            @(posedge clk);
            if (i < n_rows) begin
                m_req <= rows[i].req;
                m_addr <= rows[i].addr;
                m_w_rb <= rows[i].wr;
                m_acc <= rows[i].acc;
                m_wdata <= rows[i].data;
            end else begin
                m_req <= 1'b0; // flush the last response.
            end
            bus_halt <= (i > 0) ? rows[i-1].halt : 1'b0;
            @(negedge clk);
            if (i < n_rows)
                check_val(32'(bus_fault), 32'(rows[i].exp_fault),
                          $sformatf("row %0d bus_fault", i));
            if (i > 0) begin
                check_val(32'(m_resp), 32'(rows[i-1].exp_resp),
                          $sformatf("row %0d m_resp", i - 1));
                if (rows[i-1].chk_data)
                    check_val(m_rdata, rows[i-1].exp_rdata,
                              $sformatf("row %0d m_rdata", i - 1));
            end
        end
        $display("done: %0d rows, %0d checks, %0d errors", n_rows, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        wait (rows_ready);
        #((n_rows + rst_cycles + 2) * clk_period + 500);
        $display("watchdog: the run did not finish in the expected time, stopping");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: sim.f
logic/femto_bus_pkg.sv
logic/femto_map_pkg.sv
logic/dbus_rom.sv
logic/dbus_tcm.sv
logic/dbus_conn.sv
logic/dbus_subsys.sv
verification/tb_dbus_subsys.sv

// File: Makefile
# Verilator build of the data bus subsystem testbench.

VERILATOR ?= verilator
TOP       ?= tb_dbus_subsys
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
